//--- verilog/core_pkg.sv
package core_pkg;

  localparam int XLEN       = 32;
  localparam int REG_ADDR_W = 5;

  localparam logic [XLEN-1:0] RESET_PC = 32'hbfc0_0000;
  localparam logic [XLEN-1:0] NOP_INST = 32'h0000_0000; // sll $0,$0,0

  typedef struct packed {
    logic [5:0]            opcode;
    logic [REG_ADDR_W-1:0] rs;
    logic [REG_ADDR_W-1:0] rt;
    logic [REG_ADDR_W-1:0] rd;
    logic [4:0]            shamt;
    logic [5:0]            funct;
  } r_fmt_t;

  typedef struct packed {
    logic [5:0]            opcode;
    logic [REG_ADDR_W-1:0] rs;
    logic [REG_ADDR_W-1:0] rt;
    logic [15:0]           imm16;
  } i_fmt_t;

  typedef union packed {
    r_fmt_t r_fmt;
    i_fmt_t i_fmt;
  } inst_u;

  typedef enum logic [5:0] {
    OP_SPECIAL = 6'h00, OP_J    = 6'h02, OP_BEQ  = 6'h04, OP_BNE = 6'h05,
    OP_ADDIU   = 6'h09, OP_SLTI = 6'h0a, OP_ANDI = 6'h0c, OP_ORI = 6'h0d,
    OP_XORI    = 6'h0e, OP_LUI  = 6'h0f, OP_LW   = 6'h23, OP_SW  = 6'h2b
  } opcode_e;

  typedef enum logic [5:0] {
    F_SLL = 6'h00, F_SRL = 6'h02, F_ADDU = 6'h21, F_SUBU = 6'h23, F_AND = 6'h24,
    F_OR  = 6'h25, F_XOR = 6'h26, F_SLT  = 6'h2a, F_SLTU = 6'h2b
  } funct_e;

  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_NOR,
    ALU_SLT, ALU_SLTU, ALU_SLL, ALU_SRL, ALU_LUI
  } alu_op_e;

  typedef enum logic [1:0] {
    MEM_NONE, MEM_LOAD, MEM_STORE
  } mem_op_e;

  typedef struct packed {
    logic [XLEN-1:0] pc;
    inst_u           inst;
    logic            valid;
  } if_id_t;

  typedef struct packed {
    logic [XLEN-1:0]       pc;
    alu_op_e               alu_op;
    logic [XLEN-1:0]       opr1;
    logic [XLEN-1:0]       opr2;
    logic [XLEN-1:0]       store_data;
    mem_op_e               mem_op;
    logic                  wen;
    logic [REG_ADDR_W-1:0] waddr;
    logic                  valid;
  } id_ex_t;

  typedef struct packed {
    logic [XLEN-1:0]       pc;
    mem_op_e               mem_op;
    logic                  wen;
    logic [REG_ADDR_W-1:0] waddr;
    logic [XLEN-1:0]       wdata; // alu result or load address
    logic                  valid;
  } ex_mem_t;

  // pending write seen by the bypass network
  typedef struct packed {
    logic                  wen;
    logic [REG_ADDR_W-1:0] waddr;
    logic [XLEN-1:0]       wdata;
    logic                  is_load;
  } fwd_t;

  typedef struct packed {
    logic [XLEN-1:0]       pc;
    logic                  wen;
    logic [REG_ADDR_W-1:0] waddr;
    logic [XLEN-1:0]       wdata;
  } wb_t;

endpackage

//--- verilog/fetch_stage.sv
`timescale 1ns/100ps

module fetch_stage (
  input  logic                      clk,
  input  logic                      rst_i,
  input  logic                      stall_i,
  input  logic                      branch_taken_i,
  input  logic [core_pkg::XLEN-1:0] branch_target_i,
  input  logic [core_pkg::XLEN-1:0] inst_rdata_i,
  output logic                      inst_en_o,
  output logic [core_pkg::XLEN-1:0] inst_addr_o,
  output core_pkg::if_id_t          if_id_o
);

  logic [core_pkg::XLEN-1:0] pc_q;    // address presented this cycle
  logic [core_pkg::XLEN-1:0] pc_next;
  logic [core_pkg::XLEN-1:0] id_pc_q;
  logic                      id_valid_q;

  assign pc_next = branch_taken_i ? branch_target_i : pc_q + 32'd4;

  always_ff @(posedge clk) begin
    if (rst_i) begin
      pc_q       <= core_pkg::RESET_PC;
      id_valid_q <= 1'b0;
    end else if (!stall_i) begin
      pc_q       <= pc_next;
      id_valid_q <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (!stall_i) begin
      id_pc_q <= pc_q;
    end
  end

  assign inst_en_o = 1'b1;
  // on stall fetch the decode slot's word again so the data lines up
  assign inst_addr_o = stall_i ? id_pc_q : pc_q;

  // the word arrives one cycle after its request, same slot as its pc
  assign if_id_o.pc    = id_pc_q;
  assign if_id_o.inst  = id_valid_q ? inst_rdata_i : core_pkg::NOP_INST;
  assign if_id_o.valid = id_valid_q;

endmodule

//--- verilog/regfile.sv
`timescale 1ns/100ps

module regfile (
  input  logic                            clk,
  input  logic                            rst_i,
  input  logic [core_pkg::REG_ADDR_W-1:0] raddr1_i,
  input  logic [core_pkg::REG_ADDR_W-1:0] raddr2_i,
  input  logic                            ren1_i,
  input  logic                            ren2_i,
  input  core_pkg::fwd_t                  ex_fwd_i,
  input  core_pkg::fwd_t                  mem_fwd_i,
  input  core_pkg::wb_t                   wb_i,
  output logic [core_pkg::XLEN-1:0]       opr1_o,
  output logic [core_pkg::XLEN-1:0]       opr2_o,
  output logic                            load_use_stall_o
);

  logic [core_pkg::XLEN-1:0] rf_q [32];

  always_ff @(posedge clk) begin
    if (wb_i.wen) begin
      rf_q[wb_i.waddr] <= wb_i.wdata;
    end
  end

  // youngest pending write wins
  function automatic logic [core_pkg::XLEN-1:0] bypass(
    input logic                            ren,
    input logic [core_pkg::REG_ADDR_W-1:0] raddr,
    input core_pkg::fwd_t                  ex,
    input core_pkg::fwd_t                  mem,
    input core_pkg::wb_t                   wb,
    input logic [core_pkg::XLEN-1:0]       stored
  );
    if (!ren || raddr == '0) return '0;
    if (ex.wen && ex.waddr == raddr) return ex.wdata;
    if (mem.wen && mem.waddr == raddr) return mem.wdata;
    if (wb.wen && wb.waddr == raddr) return wb.wdata; // write-before-read
    return stored;
  endfunction

  assign opr1_o = bypass(ren1_i, raddr1_i, ex_fwd_i, mem_fwd_i, wb_i, rf_q[raddr1_i]);
  assign opr2_o = bypass(ren2_i, raddr2_i, ex_fwd_i, mem_fwd_i, wb_i, rf_q[raddr2_i]);

  // load data only exists from MEM on
  assign load_use_stall_o = ex_fwd_i.is_load && ex_fwd_i.wen && ex_fwd_i.waddr != '0 &&
                            ((ren1_i && raddr1_i == ex_fwd_i.waddr) ||
                             (ren2_i && raddr2_i == ex_fwd_i.waddr));

  a_no_r0_write: assert property (@(posedge clk) disable iff (rst_i)
    wb_i.wen |-> wb_i.waddr != '0);

endmodule

//--- verilog/decode_stage.sv
`timescale 1ns/100ps

module decode_stage (
  input  logic                            clk,
  input  logic                            rst_i,
  input  core_pkg::if_id_t                if_id_i,
  input  logic [core_pkg::XLEN-1:0]       opr1_i,
  input  logic [core_pkg::XLEN-1:0]       opr2_i,
  input  logic                            load_use_stall_i,
  output logic [core_pkg::REG_ADDR_W-1:0] raddr1_o,
  output logic [core_pkg::REG_ADDR_W-1:0] raddr2_o,
  output logic                            ren1_o,
  output logic                            ren2_o,
  output logic                            stall_o,
  output logic                            branch_taken_o,
  output logic [core_pkg::XLEN-1:0]       branch_target_o,
  output core_pkg::id_ex_t                id_ex_o
);

  core_pkg::r_fmt_t          r_inst;
  core_pkg::i_fmt_t          i_inst;
  core_pkg::alu_op_e         alu_op;
  core_pkg::mem_op_e         mem_op;
  logic                      use_imm;
  logic                      sign_ext;
  logic                      use_shamt;
  logic                      use_rd;
  logic                      wen;
  logic                      ren1;
  logic                      ren2;
  logic                      is_beq;
  logic                      is_bne;
  logic                      is_j;
  logic [core_pkg::XLEN-1:0] imm_ext;
  logic [core_pkg::XLEN-1:0] slot_pc;
  logic [core_pkg::XLEN-1:0] br_target;
  logic [core_pkg::XLEN-1:0] j_target;
  core_pkg::id_ex_t          id_ex_q;

  assign r_inst = if_id_i.inst.r_fmt;
  assign i_inst = if_id_i.inst.i_fmt;

  always_comb begin
    alu_op    = core_pkg::ALU_ADD;
    mem_op    = core_pkg::MEM_NONE;
    use_imm   = 1'b1;
    sign_ext  = 1'b0;
    use_shamt = 1'b0;
    use_rd    = 1'b0;
    wen       = 1'b1;
    ren1      = 1'b1;
    ren2      = 1'b0;
    is_beq    = 1'b0;
    is_bne    = 1'b0;
    is_j      = 1'b0;
    case (i_inst.opcode)
      core_pkg::OP_SPECIAL: begin
        use_imm = 1'b0;
        use_rd  = 1'b1;
        ren2    = 1'b1;
        case (r_inst.funct)
          core_pkg::F_ADDU: alu_op = core_pkg::ALU_ADD;
          core_pkg::F_SUBU: alu_op = core_pkg::ALU_SUB;
          core_pkg::F_AND:  alu_op = core_pkg::ALU_AND;
          core_pkg::F_OR:   alu_op = core_pkg::ALU_OR;
          core_pkg::F_XOR:  alu_op = core_pkg::ALU_XOR;
          core_pkg::F_SLT:  alu_op = core_pkg::ALU_SLT;
          core_pkg::F_SLTU: alu_op = core_pkg::ALU_SLTU;
          core_pkg::F_SLL: begin
            alu_op    = core_pkg::ALU_SLL;
            use_shamt = 1'b1;
            ren1      = 1'b0;
          end
          core_pkg::F_SRL: begin
            alu_op    = core_pkg::ALU_SRL;
            use_shamt = 1'b1;
            ren1      = 1'b0;
          end
          default: wen = 1'b0; // unknown funct does nothing
        endcase
      end
      core_pkg::OP_ADDIU: sign_ext = 1'b1;
      core_pkg::OP_SLTI: begin
        alu_op   = core_pkg::ALU_SLT;
        sign_ext = 1'b1;
      end
      core_pkg::OP_ANDI: alu_op = core_pkg::ALU_AND;
      core_pkg::OP_ORI:  alu_op = core_pkg::ALU_OR;
      core_pkg::OP_XORI: alu_op = core_pkg::ALU_XOR;
      core_pkg::OP_LUI: begin
        alu_op = core_pkg::ALU_LUI;
        ren1   = 1'b0;
      end
      core_pkg::OP_LW: begin
        sign_ext = 1'b1;
        mem_op   = core_pkg::MEM_LOAD;
      end
      core_pkg::OP_SW: begin
        sign_ext = 1'b1;
        mem_op   = core_pkg::MEM_STORE;
        wen      = 1'b0;
        ren2     = 1'b1; // store data
      end
      core_pkg::OP_BEQ: begin
        is_beq = 1'b1;
        wen    = 1'b0;
        ren2   = 1'b1;
      end
      core_pkg::OP_BNE: begin
        is_bne = 1'b1;
        wen    = 1'b0;
        ren2   = 1'b1;
      end
      core_pkg::OP_J: begin
        is_j = 1'b1;
        wen  = 1'b0;
        ren1 = 1'b0;
      end
      default: begin
        wen  = 1'b0;
        ren1 = 1'b0;
      end
    endcase
  end

  assign imm_ext = sign_ext ? {{16{i_inst.imm16[15]}}, i_inst.imm16} : {16'h0, i_inst.imm16};

  // targets are relative to the delay slot
  assign slot_pc   = if_id_i.pc + 32'd4;
  assign br_target = slot_pc + {{14{i_inst.imm16[15]}}, i_inst.imm16, 2'b00};
  assign j_target  = {slot_pc[31:28], i_inst.rs, i_inst.rt, i_inst.imm16, 2'b00};

  assign raddr1_o = i_inst.rs;
  assign raddr2_o = i_inst.rt;
  assign ren1_o   = if_id_i.valid & ren1;
  assign ren2_o   = if_id_i.valid & ren2;
  assign stall_o  = load_use_stall_i;

  // operands are stale while stalled, so hold off the redirect
  assign branch_taken_o = if_id_i.valid & ~load_use_stall_i &
                          (is_j | (is_beq & (opr1_i == opr2_i)) | (is_bne & (opr1_i != opr2_i)));
  assign branch_target_o = is_j ? j_target : br_target;

  always_ff @(posedge clk) begin
    id_ex_q.pc         <= if_id_i.pc;
    id_ex_q.alu_op     <= alu_op;
    id_ex_q.opr1       <= use_shamt ? {{(core_pkg::XLEN-5){1'b0}}, r_inst.shamt} : opr1_i;
    id_ex_q.opr2       <= use_imm ? imm_ext : opr2_i;
    id_ex_q.store_data <= opr2_i;
    id_ex_q.waddr      <= use_rd ? r_inst.rd : i_inst.rt;
    if (rst_i || load_use_stall_i || !if_id_i.valid) begin
      id_ex_q.valid  <= 1'b0; // bubble
      id_ex_q.wen    <= 1'b0;
      id_ex_q.mem_op <= core_pkg::MEM_NONE;
    end else begin
      id_ex_q.valid  <= 1'b1;
      id_ex_q.wen    <= wen;
      id_ex_q.mem_op <= mem_op;
    end
  end

  assign id_ex_o = id_ex_q;

  // the bubble leaves no load in EX, so a stall never lasts two cycles
  a_single_bubble: assert property (@(posedge clk) disable iff (rst_i)
    load_use_stall_i |=> !load_use_stall_i);

endmodule

//--- verilog/execute_stage.sv
`timescale 1ns/100ps

module execute_stage (
  input  logic                      clk,
  input  logic                      rst_i,
  input  core_pkg::id_ex_t          id_ex_i,
  output logic                      data_en_o,
  output logic [3:0]                data_wen_o,
  output logic [core_pkg::XLEN-1:0] data_addr_o,
  output logic [core_pkg::XLEN-1:0] data_wdata_o,
  output core_pkg::fwd_t            ex_fwd_o,
  output core_pkg::ex_mem_t         ex_mem_o
);

  logic [core_pkg::XLEN-1:0] opr1;
  logic [core_pkg::XLEN-1:0] opr2;
  logic [core_pkg::XLEN-1:0] alu_res;
  logic                      is_load;
  logic                      is_store;
  core_pkg::ex_mem_t         ex_mem_q;

  assign opr1 = id_ex_i.opr1;
  assign opr2 = id_ex_i.opr2;

  always_comb begin
    case (id_ex_i.alu_op)
      core_pkg::ALU_ADD:  alu_res = opr1 + opr2;
      core_pkg::ALU_SUB:  alu_res = opr1 - opr2;
      core_pkg::ALU_AND:  alu_res = opr1 & opr2;
      core_pkg::ALU_OR:   alu_res = opr1 | opr2;
      core_pkg::ALU_XOR:  alu_res = opr1 ^ opr2;
      core_pkg::ALU_NOR:  alu_res = ~(opr1 | opr2);
      core_pkg::ALU_SLT:  alu_res = {31'h0, $signed(opr1) < $signed(opr2)};
      core_pkg::ALU_SLTU: alu_res = {31'h0, opr1 < opr2};
      core_pkg::ALU_SLL:  alu_res = opr2 << opr1[4:0]; // shamt in opr1
      core_pkg::ALU_SRL:  alu_res = opr2 >> opr1[4:0];
      core_pkg::ALU_LUI:  alu_res = {opr2[15:0], 16'h0};
      default:            alu_res = '0;
    endcase
  end

  assign is_load  = id_ex_i.valid && id_ex_i.mem_op == core_pkg::MEM_LOAD;
  assign is_store = id_ex_i.valid && id_ex_i.mem_op == core_pkg::MEM_STORE;

  assign data_en_o    = is_load | is_store;
  assign data_wen_o   = {4{is_store}}; // word stores only
  assign data_addr_o  = alu_res;
  assign data_wdata_o = id_ex_i.store_data;

  assign ex_fwd_o.wen     = id_ex_i.wen;
  assign ex_fwd_o.waddr   = id_ex_i.waddr;
  assign ex_fwd_o.wdata   = alu_res;
  assign ex_fwd_o.is_load = is_load;

  always_ff @(posedge clk) begin
    ex_mem_q.pc    <= id_ex_i.pc;
    ex_mem_q.waddr <= id_ex_i.waddr;
    ex_mem_q.wdata <= alu_res;
    if (rst_i) begin
      ex_mem_q.valid  <= 1'b0;
      ex_mem_q.wen    <= 1'b0;
      ex_mem_q.mem_op <= core_pkg::MEM_NONE;
    end else begin
      ex_mem_q.valid  <= id_ex_i.valid;
      ex_mem_q.wen    <= id_ex_i.wen;
      ex_mem_q.mem_op <= id_ex_i.mem_op;
    end
  end

  assign ex_mem_o = ex_mem_q;

  a_word_aligned: assert property (@(posedge clk) disable iff (rst_i)
    data_en_o |-> data_addr_o[1:0] == 2'b00);

endmodule

//--- verilog/mem_wb_stage.sv
`timescale 1ns/100ps

module mem_wb_stage (
  input  logic                            clk,
  input  logic                            rst_i,
  input  core_pkg::ex_mem_t               ex_mem_i,
  input  logic [core_pkg::XLEN-1:0]       data_rdata_i,
  output core_pkg::fwd_t                  mem_fwd_o,
  output core_pkg::wb_t                   wb_o,
  output logic [core_pkg::XLEN-1:0]       debug_wb_pc_o,
  output logic [3:0]                      debug_wb_rf_wen_o,
  output logic [core_pkg::REG_ADDR_W-1:0] debug_wb_rf_wnum_o,
  output logic [core_pkg::XLEN-1:0]       debug_wb_rf_wdata_o
);

  logic                      is_load;
  logic [core_pkg::XLEN-1:0] result;
  core_pkg::wb_t             wb_q;

  assign is_load = ex_mem_i.mem_op == core_pkg::MEM_LOAD;
  assign result  = is_load ? data_rdata_i : ex_mem_i.wdata; // read data lands this cycle

  assign mem_fwd_o.wen     = ex_mem_i.wen;
  assign mem_fwd_o.waddr   = ex_mem_i.waddr;
  assign mem_fwd_o.wdata   = result;
  assign mem_fwd_o.is_load = is_load;

  always_ff @(posedge clk) begin
    wb_q.pc    <= ex_mem_i.pc;
    wb_q.waddr <= ex_mem_i.waddr;
    wb_q.wdata <= result;
    if (rst_i) begin
      wb_q.wen <= 1'b0;
    end else begin
      // $0 writes retire silently
      wb_q.wen <= ex_mem_i.valid && ex_mem_i.wen && ex_mem_i.waddr != '0;
    end
  end

  assign wb_o = wb_q;

  assign debug_wb_pc_o       = wb_q.pc;
  assign debug_wb_rf_wen_o   = {4{wb_q.wen}};
  assign debug_wb_rf_wnum_o  = wb_q.waddr;
  assign debug_wb_rf_wdata_o = wb_q.wdata;

endmodule

//--- verilog/mycpu_core_top.sv
`timescale 1ns/100ps

module mycpu_core_top (
  input  logic                            clk,
  input  logic                            rst_i,
  // instruction port
  output logic                            inst_en_o,
  output logic [core_pkg::XLEN-1:0]       inst_addr_o,
  input  logic [core_pkg::XLEN-1:0]       inst_rdata_i,
  // data port
  output logic                            data_en_o,
  output logic [3:0]                      data_wen_o,
  output logic [core_pkg::XLEN-1:0]       data_addr_o,
  output logic [core_pkg::XLEN-1:0]       data_wdata_o,
  input  logic [core_pkg::XLEN-1:0]       data_rdata_i,
  // retirement trace
  output logic [core_pkg::XLEN-1:0]       debug_wb_pc_o,
  output logic [3:0]                      debug_wb_rf_wen_o,
  output logic [core_pkg::REG_ADDR_W-1:0] debug_wb_rf_wnum_o,
  output logic [core_pkg::XLEN-1:0]       debug_wb_rf_wdata_o
);

  core_pkg::if_id_t                if_id;
  core_pkg::id_ex_t                id_ex;
  core_pkg::ex_mem_t               ex_mem;
  core_pkg::fwd_t                  ex_fwd;
  core_pkg::fwd_t                  mem_fwd;
  core_pkg::wb_t                   wb;
  logic [core_pkg::REG_ADDR_W-1:0] raddr1;
  logic [core_pkg::REG_ADDR_W-1:0] raddr2;
  logic                            ren1;
  logic                            ren2;
  logic [core_pkg::XLEN-1:0]       opr1;
  logic [core_pkg::XLEN-1:0]       opr2;
  logic                            load_use_stall;
  logic                            stall;
  logic                            branch_taken;
  logic [core_pkg::XLEN-1:0]       branch_target;

  fetch_stage u_fetch (
    .clk             (clk),
    .rst_i           (rst_i),
    .stall_i         (stall),
    .branch_taken_i  (branch_taken),
    .branch_target_i (branch_target),
    .inst_rdata_i    (inst_rdata_i),
    .inst_en_o       (inst_en_o),
    .inst_addr_o     (inst_addr_o),
    .if_id_o         (if_id)
  );

  decode_stage u_decode (
    .clk              (clk),
    .rst_i            (rst_i),
    .if_id_i          (if_id),
    .opr1_i           (opr1),
    .opr2_i           (opr2),
    .load_use_stall_i (load_use_stall),
    .raddr1_o         (raddr1),
    .raddr2_o         (raddr2),
    .ren1_o           (ren1),
    .ren2_o           (ren2),
    .stall_o          (stall),
    .branch_taken_o   (branch_taken),
    .branch_target_o  (branch_target),
    .id_ex_o          (id_ex)
  );

  regfile u_regfile (
    .clk              (clk),
    .rst_i            (rst_i),
    .raddr1_i         (raddr1),
    .raddr2_i         (raddr2),
    .ren1_i           (ren1),
    .ren2_i           (ren2),
    .ex_fwd_i         (ex_fwd),
    .mem_fwd_i        (mem_fwd),
    .wb_i             (wb),
    .opr1_o           (opr1),
    .opr2_o           (opr2),
    .load_use_stall_o (load_use_stall)
  );

  execute_stage u_execute (
    .clk          (clk),
    .rst_i        (rst_i),
    .id_ex_i      (id_ex),
    .data_en_o    (data_en_o),
    .data_wen_o   (data_wen_o),
    .data_addr_o  (data_addr_o),
    .data_wdata_o (data_wdata_o),
    .ex_fwd_o     (ex_fwd),
    .ex_mem_o     (ex_mem)
  );

  mem_wb_stage u_mem_wb (
    .clk                 (clk),
    .rst_i               (rst_i),
    .ex_mem_i            (ex_mem),
    .data_rdata_i        (data_rdata_i),
    .mem_fwd_o           (mem_fwd),
    .wb_o                (wb),
    .debug_wb_pc_o       (debug_wb_pc_o),
    .debug_wb_rf_wen_o   (debug_wb_rf_wen_o),
    .debug_wb_rf_wnum_o  (debug_wb_rf_wnum_o),
    .debug_wb_rf_wdata_o (debug_wb_rf_wdata_o)
  );

endmodule

//--- verif/core_tb.sv
`timescale 1ns/100ps

module core_tb;

  localparam int N_PROGS    = 20;
  localparam int N_RAND     = 60;
  localparam int END_IDX    = N_RAND;     // self-branch slot
  localparam int PROG_LEN   = N_RAND + 2;
  localparam int IMEM_WORDS = 1024;
  localparam int DMEM_WORDS = 256;
  localparam int DRAIN      = 8;          // five stages plus margin
  localparam int MAX_CYCLES = N_PROGS * (N_RAND * 8 + 50);
  localparam int SEED       = 11854;

  typedef struct packed {
    logic [31:0] pc;
    logic [4:0]  wnum;
    logic [31:0] wdata;
  } retire_t;

  logic        clk = 1'b0;
  logic        rst_i;
  logic        inst_en_o;
  logic [31:0] inst_addr_o;
  logic [31:0] inst_rdata_i;
  logic        data_en_o;
  logic [3:0]  data_wen_o;
  logic [31:0] data_addr_o;
  logic [31:0] data_wdata_o;
  logic [31:0] data_rdata_i;
  logic [31:0] debug_wb_pc_o;
  logic [3:0]  debug_wb_rf_wen_o;
  logic [4:0]  debug_wb_rf_wnum_o;
  logic [31:0] debug_wb_rf_wdata_o;

  logic [31:0] imem [IMEM_WORDS];
  logic [31:0] prog [PROG_LEN];
  logic [31:0] dmem [DMEM_WORDS];
  logic [31:0] mmem [DMEM_WORDS];  // model copy
  logic [31:0] mregs [32];
  retire_t     exp_q [$];
  string       cur_test;
  logic        end_fetched;
  logic        prev_rst;
  logic [31:0] next_inst;
  logic [31:0] next_data;
  int          cycles;

  mycpu_core_top mycpu_core_top_inst (
    .clk                 (clk),
    .rst_i               (rst_i),
    .inst_en_o           (inst_en_o),
    .inst_addr_o         (inst_addr_o),
    .inst_rdata_i        (inst_rdata_i),
    .data_en_o           (data_en_o),
    .data_wen_o          (data_wen_o),
    .data_addr_o         (data_addr_o),
    .data_wdata_o        (data_wdata_o),
    .data_rdata_i        (data_rdata_i),
    .debug_wb_pc_o       (debug_wb_pc_o),
    .debug_wb_rf_wen_o   (debug_wb_rf_wen_o),
    .debug_wb_rf_wnum_o  (debug_wb_rf_wnum_o),
    .debug_wb_rf_wdata_o (debug_wb_rf_wdata_o)
  );

  initial begin
    forever #2 clk = ~clk;
  end

  task automatic check_value(input string name, input logic [31:0] exp,
                             input logic [31:0] act);
    if (act !== exp) begin
      $display("error: %s expected %h actual %h", name, exp, act);
      $display("sim failed");
      $fatal(1);
    end
  endtask

  task automatic report_failure(input string what);
    $display("%s", what);
    $display("sim failed");
    $fatal(1);
  endtask

  // sources come from r0..r7 which the setup writes
  function automatic logic [4:0] pick_src();
    return 5'($urandom_range(7, 0));
  endfunction

  function automatic logic [4:0] pick_dst();
    if ($urandom_range(7, 0) == 0) begin
      return 5'($urandom_range(31, 8));
    end
    return 5'($urandom_range(7, 0));
  endfunction

  function automatic logic [5:0] pick_funct();
    case ($urandom_range(6, 0))
      0: return 6'h21;  // addu
      1: return 6'h23;  // subu
      2: return 6'h24;  // and
      3: return 6'h25;  // or
      4: return 6'h26;  // xor
      5: return 6'h2a;  // slt
      default: return 6'h2b;  // sltu
    endcase
  endfunction

  function automatic logic [5:0] pick_iop();
    case ($urandom_range(4, 0))
      0: return 6'h09;  // addiu
      1: return 6'h0a;  // slti
      2: return 6'h0c;  // andi
      3: return 6'h0d;  // ori
      default: return 6'h0e;  // xori
    endcase
  endfunction

  function automatic logic [31:0] enc_r(input logic [4:0] rs, input logic [4:0] rt,
                                       input logic [4:0] rd, input logic [4:0] sh,
                                       input logic [5:0] fn);
    return {6'h00, rs, rt, rd, sh, fn};
  endfunction

  function automatic logic [31:0] enc_i(input logic [5:0] op, input logic [4:0] rs,
                                       input logic [4:0] rt, input logic [15:0] imm);
    return {op, rs, rt, imm};
  endfunction

  task automatic gen_program();
    logic        prev_br;
    logic        br_ok;
    int unsigned kind;
    int          k;
    logic [4:0]  rs;
    logic [4:0]  rt;
    logic [4:0]  rd;
    logic [15:0] imm;
    logic [31:0] tgt;
    prev_br = 1'b0;
    for (int i = 0; i < N_RAND; i++) begin
      rs    = pick_src();
      rt    = pick_src();
      rd    = pick_dst();
      imm   = 16'($urandom);
      kind  = $urandom_range(15, 0);
      br_ok = !prev_br && i < N_RAND - 1;  // no branch in a delay slot
      k     = $urandom_range(6, 2);
      if (i + k > END_IDX) begin
        k = END_IDX - i;
      end
      prev_br = 1'b0;
      if (i < 7) begin
        prog[i] = enc_i(6'h09, 5'd0, 5'(i + 1), imm);  // set up r1..r7
      end else if (kind < 5) begin
        prog[i] = enc_r(rs, rt, rd, 5'd0, pick_funct());
      end else if (kind == 5) begin
        prog[i] = enc_r(5'd0, rt, rd, imm[4:0], imm[8] ? 6'h02 : 6'h00);
      end else if (kind < 9) begin
        prog[i] = enc_i(pick_iop(), rs, rd, imm);
      end else if (kind == 9) begin
        prog[i] = enc_i(6'h0f, 5'd0, rd, imm);  // lui
      end else if (kind < 12) begin
        prog[i] = enc_i(6'h23, 5'd0, rd, {6'h0, imm[7:0], 2'b00});  // lw
      end else if (kind == 12) begin
        prog[i] = enc_i(6'h2b, 5'd0, rt, {6'h0, imm[7:0], 2'b00});  // sw
      end else if (kind < 15 && br_ok) begin
        prog[i] = enc_i(kind == 13 ? 6'h04 : 6'h05, rs, rt, 16'(k - 1));
        prev_br = 1'b1;
      end else if (kind == 15 && br_ok) begin
        tgt     = core_pkg::RESET_PC + 32'((i + k) * 4);
        prog[i] = {6'h02, tgt[27:2]};  // j
        prev_br = 1'b1;
      end else begin
        prog[i] = enc_r(rs, rt, rd, 5'd0, pick_funct());
      end
    end
    prog[END_IDX]     = {6'h04, 5'd0, 5'd0, 16'hffff};  // beq $0,$0,-1
    prog[END_IDX + 1] = 32'h0;
  endtask

  task automatic load_program();
    for (int i = 0; i < PROG_LEN; i++) begin
      imem[i] = prog[i];
    end
    for (int w = 0; w < DMEM_WORDS; w++) begin
      dmem[w] = $urandom;
      mmem[w] = dmem[w];
    end
    exp_q.delete();
    end_fetched = 1'b0;
  endtask

  // one instruction of the ISA model
  task automatic exec_one(input int idx, output logic taken, output int tgt_idx);
    logic [31:0] w;
    logic [31:0] pc;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] simm;
    logic [31:0] zimm;
    logic [31:0] res;
    logic [31:0] addr;
    logic [4:0]  dst;
    logic        wr;
    retire_t     e;
    w       = prog[idx];
    pc      = core_pkg::RESET_PC + 32'(idx * 4);
    a       = mregs[w[25:21]];
    b       = mregs[w[20:16]];
    simm    = {{16{w[15]}}, w[15:0]};
    zimm    = {16'h0, w[15:0]};
    dst     = w[20:16];
    wr      = 1'b1;
    res     = 32'h0;
    addr    = 32'h0;
    taken   = 1'b0;
    tgt_idx = 0;
    case (w[31:26])
      6'h00: begin
        dst = w[15:11];
        case (w[5:0])
          6'h21: res = a + b;
          6'h23: res = a - b;
          6'h24: res = a & b;
          6'h25: res = a | b;
          6'h26: res = a ^ b;
          6'h2a: res = {31'h0, $signed(a) < $signed(b)};
          6'h2b: res = {31'h0, a < b};
          6'h00: res = b << w[10:6];
          6'h02: res = b >> w[10:6];
          default: wr = 1'b0;
        endcase
      end
      6'h09: res = a + simm;
      6'h0a: res = {31'h0, $signed(a) < $signed(simm)};
      6'h0c: res = a & zimm;
      6'h0d: res = a | zimm;
      6'h0e: res = a ^ zimm;
      6'h0f: res = {w[15:0], 16'h0};
      6'h23: begin
        addr = a + simm;
        res  = mmem[addr[9:2]];
      end
      6'h2b: begin
        addr            = a + simm;
        mmem[addr[9:2]] = b;
        wr              = 1'b0;
      end
      6'h04, 6'h05: begin
        taken = (w[26] == 1'b0) ? (a == b) : (a != b);
        addr  = pc + 32'd4 + {simm[29:0], 2'b00};  // from the delay slot
        wr    = 1'b0;
      end
      6'h02: begin
        taken = 1'b1;
        addr  = pc + 32'd4;
        addr  = {addr[31:28], w[25:0], 2'b00};
        wr    = 1'b0;
      end
      default: wr = 1'b0;
    endcase
    if (taken) begin
      tgt_idx = int'((addr - core_pkg::RESET_PC) >> 2);
    end
    if (wr && dst != 5'd0) begin
      mregs[dst] = res;
      e.pc       = pc;
      e.wnum     = dst;
      e.wdata    = res;
      exp_q.push_back(e);
    end
  endtask

  task automatic run_model();
    int   idx;
    int   tgt;
    int   slot_tgt;
    logic taken;
    logic slot_taken;
    for (int r = 0; r < 32; r++) begin
      mregs[r] = 32'h0;
    end
    idx = 0;
    while (idx != END_IDX) begin
      exec_one(idx, taken, tgt);
      if (taken) begin
        exec_one(idx + 1, slot_taken, slot_tgt);  // delay slot
        idx = tgt;
      end else begin
        idx = idx + 1;
      end
    end
  endtask

  task automatic serve_fetch();
    logic [31:0] off;
    off       = inst_addr_o - core_pkg::RESET_PC;
    next_inst = 32'h0;
    if (inst_en_o) begin
      if (off < 32'(PROG_LEN * 4)) begin
        next_inst = imem[off[11:2]];
        if (!rst_i && off == 32'(END_IDX * 4)) begin
          end_fetched = 1'b1;
        end
      end else if (!rst_i) begin
        report_failure("instruction fetch outside the loaded program");
      end
    end
  endtask

  task automatic serve_data();
    next_data = 32'h0;
    if (data_wen_o != 4'h0 && data_wen_o != 4'hf) begin
      report_failure("data_wen_o is neither all four bytes nor none");
    end else if (data_wen_o != 4'h0 && !data_en_o) begin
      report_failure("data_wen_o is set while data_en_o is low");
    end else if (data_en_o) begin
      if (data_addr_o >= 32'(DMEM_WORDS * 4)) begin
        report_failure("data access outside the data memory");
      end else if (data_wen_o == 4'hf) begin
        dmem[data_addr_o[9:2]] = data_wdata_o;
      end else begin
        next_data = dmem[data_addr_o[9:2]];
      end
    end
  endtask

  task automatic check_retire();
    retire_t e;
    if (debug_wb_rf_wen_o != 4'h0 && debug_wb_rf_wen_o != 4'hf) begin
      report_failure("debug_wb_rf_wen_o shows a partial byte enable");
    end else if (debug_wb_rf_wen_o == 4'hf) begin
      if (exp_q.size() == 0) begin
        report_failure("a register write retired while the model expects none");
      end else begin
        e = exp_q.pop_front();
        check_value($sformatf("%s retire pc", cur_test), e.pc, debug_wb_pc_o);
        check_value($sformatf("%s retire wnum", cur_test), {27'h0, e.wnum},
                    {27'h0, debug_wb_rf_wnum_o});
        check_value($sformatf("%s retire wdata", cur_test), e.wdata, debug_wb_rf_wdata_o);
      end
    end
  endtask

  // memories sample mid-cycle and answer 1 ns after the edge
  initial begin
    prev_rst = 1'b1;
    forever begin
      @(negedge clk);
      if (prev_rst) begin
        check_value($sformatf("%s reset rf_wen", cur_test), 32'h0, {28'h0, debug_wb_rf_wen_o});
        check_value($sformatf("%s reset data_wen", cur_test), 32'h0, {28'h0, data_wen_o});
        if (!rst_i) begin
          check_value($sformatf("%s first inst_en", cur_test), 32'h1, {31'h0, inst_en_o});
          check_value($sformatf("%s first inst_addr", cur_test), core_pkg::RESET_PC,
                      inst_addr_o);
        end
      end
      serve_fetch();
      serve_data();
      check_retire();
      prev_rst = rst_i;
      @(posedge clk);
      #1;
      inst_rdata_i = next_inst;
      data_rdata_i = next_data;
    end
  end

  initial begin
    cycles = 0;
    while (cycles <= MAX_CYCLES) begin
      @(posedge clk);
      cycles++;
    end
    $display("timeout after %0d cycles, the core never finished", cycles);
    $display("sim failed");
    $fatal(1);
  end

  task automatic wait_done();
    while (exp_q.size() != 0 || !end_fetched) begin
      @(posedge clk);
      #1;
    end
    repeat (DRAIN) begin  // last stores leave the pipe
      @(posedge clk);
      #1;
    end
  endtask

  task automatic compare_memory();
    for (int w = 0; w < DMEM_WORDS; w++) begin
      check_value($sformatf("%s dmem[%0d]", cur_test, w), mmem[w], dmem[w]);
    end
  endtask

  initial begin
    rst_i        = 1'b1;
    inst_rdata_i = 32'h0;
    data_rdata_i = 32'h0;
    end_fetched  = 1'b0;
    cur_test     = "reset";
    void'($urandom(SEED));
    for (int p = 0; p < N_PROGS; p++) begin
      rst_i = 1'b1;
      @(posedge clk);
      #1;
      cur_test = $sformatf("prog %0d", p);
      gen_program();
      load_program();
      run_model();
      repeat (7) begin
        @(posedge clk);
        #1;
      end
      rst_i = 1'b0;
      wait_done();
      compare_memory();
    end
    $display("sim passed");
    $finish;
  end

endmodule

//--- vlog.f
verilog/core_pkg.sv
verilog/fetch_stage.sv
verilog/regfile.sv
verilog/decode_stage.sv
verilog/execute_stage.sv
verilog/mem_wb_stage.sv
verilog/mycpu_core_top.sv
verif/core_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       := core_tb
FILELIST  := vlog.f
VFLAGS    := --binary --timing --assert -j 0 --top-module $(TOP)
LINTFLAGS := --lint-only --timing --top-module $(TOP)

.PHONY: all build lint clean

all: build
	./obj_dir/V$(TOP)

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST)

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST)

clean:
	rm -rf obj_dir
